// File: Makefile
all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
		--top-module tb_axil_2m16s -Mdir obj_dir -o sim_tb

run: compile
	./obj_dir/sim_tb | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: hw/axil_2m16s_top.sv
`timescale 1ns/1ps

module axil_2m16s_top import axil_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // m0, processor core
    input  wr_req_t                 m0_wr_req,
    input  logic                    m0_wr_valid,
    output logic                    m0_wr_ready,
    output logic                    m0_bvalid,
    output resp_t                   m0_bresp,
    input  logic                    m0_bready,
    input  addr_t                   m0_araddr,
    input  logic                    m0_arvalid,
    output logic                    m0_arready,
    output data_t                   m0_rdata,
    output logic                    m0_rvalid,
    output resp_t                   m0_rresp,
    input  logic                    m0_rready,
    // m1, debug port
    input  wr_req_t                 m1_wr_req,
    input  logic                    m1_wr_valid,
    output logic                    m1_wr_ready,
    output logic                    m1_bvalid,
    output resp_t                   m1_bresp,
    input  logic                    m1_bready,
    input  addr_t                   m1_araddr,
    input  logic                    m1_arvalid,
    output logic                    m1_arready,
    output data_t                   m1_rdata,
    output logic                    m1_rvalid,
    output resp_t                   m1_rresp,
    input  logic                    m1_rready,
    // shared slave ports
    output s_wr_t  [num_slaves-1:0] s_wr,
    output s_rd_t  [num_slaves-1:0] s_rd,
    input  s_rsp_t [num_slaves-1:0] s_rsp
);

    logic  wr_grant_valid, wr_grant, wr_done;
    logic  rd_grant_valid, rd_grant, rd_done;
    resp_t bresp;
    resp_t rresp;
    data_t rdata;

    // response payload goes to both, valid picks the owner
    assign m0_bresp = bresp;
    assign m1_bresp = bresp;
    assign m0_rresp = rresp;
    assign m1_rresp = rresp;
    assign m0_rdata = rdata;
    assign m1_rdata = rdata;

    master_arbiter wr_arb (.clk(clk), .rst(rst), .req({m1_wr_valid, m0_wr_valid}),
        .done(wr_done), .grant_valid(wr_grant_valid), .grant(wr_grant));

    master_arbiter rd_arb (.clk(clk), .rst(rst), .req({m1_arvalid, m0_arvalid}),
        .done(rd_done), .grant_valid(rd_grant_valid), .grant(rd_grant));

    write_path u_write_path (.clk(clk), .rst(rst), .grant_valid(wr_grant_valid),
        .grant(wr_grant), .m0_wr_req(m0_wr_req), .m1_wr_req(m1_wr_req),
        .m0_bready(m0_bready), .m1_bready(m1_bready), .s_rsp(s_rsp),
        .m0_wr_ready(m0_wr_ready), .m1_wr_ready(m1_wr_ready), .m0_bvalid(m0_bvalid),
        .m1_bvalid(m1_bvalid), .bresp(bresp), .s_wr(s_wr), .done(wr_done));

    read_path u_read_path (.clk(clk), .rst(rst), .grant_valid(rd_grant_valid),
        .grant(rd_grant), .m0_araddr(m0_araddr), .m1_araddr(m1_araddr),
        .m0_rready(m0_rready), .m1_rready(m1_rready), .s_rsp(s_rsp),
        .m0_arready(m0_arready), .m1_arready(m1_arready), .m0_rvalid(m0_rvalid),
        .m1_rvalid(m1_rvalid), .rdata(rdata), .rresp(rresp), .s_rd(s_rd),
        .done(rd_done));

endmodule

// File: hw/axil_pkg.sv
package axil_pkg;

    localparam int addr_w     = 32;
    localparam int data_w     = 32;
    localparam int num_slaves = 16;
    localparam int sel_w      = 4;     // slave index from top address bits

    typedef logic [addr_w-1:0]   addr_t;
    typedef logic [data_w-1:0]   data_t;
    typedef logic [data_w/8-1:0] strb_t;
    typedef logic [1:0]          resp_t;
    typedef logic [sel_w-1:0]    slave_idx_t;

    localparam resp_t resp_okay = 2'b00;

    // one write request as the master presents it
    typedef struct packed {
        addr_t addr;
        data_t data;
        strb_t strb;
    } wr_req_t;

    typedef struct packed {
        addr_t awaddr;
        logic  awvalid;
        data_t wdata;
        strb_t wstrb;
        logic  wvalid;
    } s_wr_t;

    typedef struct packed {
        addr_t araddr;
        logic  arvalid;
        logic  rready;
    } s_rd_t;

    // everything a slave drives back
    typedef struct packed {
        logic  awready;
        logic  wready;
        logic  arready;
        data_t rdata;
        logic  rvalid;
    } s_rsp_t;

    typedef enum logic [1:0] {wr_idle, wr_send, wr_resp} wr_state_t;
    typedef enum logic [1:0] {rd_idle, rd_addr, rd_data, rd_resp} rd_state_t;

endpackage

// File: hw/master_arbiter.sv
`timescale 1ns/1ps

module master_arbiter (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] req,          // bit 0 core, bit 1 debug port
    input  logic       done,         // path finished the granted transfer
    output logic       grant_valid,
    output logic       grant         // granted master id
);

    logic next_grant;

    // master 0 wins whenever it asks
    assign next_grant = ~req[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_valid <= 1'b0;
            grant       <= 1'b0;
        end else if (grant_valid) begin
            if (done) begin
                grant_valid <= 1'b0;     // lock released, free next cycle
            end
        end else if (|req) begin
            grant_valid <= 1'b1;
            grant       <= next_grant;
        end
    end

    // the grant is locked for the whole transfer, until the path reports done
    a_grant_locked: assert property (
        @(posedge clk) disable iff (rst)
        grant_valid && !done |=> grant_valid && $stable(grant)
    );

    // a path only finishes a transfer it was granted
    a_done_granted: assert property (
        @(posedge clk) disable iff (rst)
        done |-> grant_valid
    );

endmodule

// File: hw/read_path.sv
`timescale 1ns/1ps

module read_path import axil_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    grant_valid,
    input  logic                    grant,
    input  addr_t                   m0_araddr,
    input  addr_t                   m1_araddr,
    input  logic                    m0_rready,
    input  logic                    m1_rready,
    input  s_rsp_t [num_slaves-1:0] s_rsp,
    output logic                    m0_arready,
    output logic                    m1_arready,
    output logic                    m0_rvalid,
    output logic                    m1_rvalid,
    output data_t                   rdata,
    output resp_t                   rresp,
    output s_rd_t  [num_slaves-1:0] s_rd,
    output logic                    done
);

    rd_state_t             state;
    addr_t                 addr_q;       // address forwarded to the slave
    slave_idx_t            sel_q;        // slave serving this read
    logic                  mst_q;        // master that gets the data
    data_t                 rdata_q;
    logic [num_slaves-1:0] arvalid_vec;
    logic [num_slaves-1:0] rready_vec;
    logic                  take;
    addr_t                 araddr_sel;
    logic                  ar_hs;
    logic                  r_hs;
    logic                  rready_sel;

    assign take       = (state == rd_idle) && grant_valid;
    assign araddr_sel = grant ? m1_araddr : m0_araddr;

    assign m0_arready = take && !grant;
    assign m1_arready = take && grant;

    assign ar_hs = arvalid_vec[sel_q] && s_rsp[sel_q].arready;
    assign r_hs  = rready_vec[sel_q] && s_rsp[sel_q].rvalid;

    assign m0_rvalid  = (state == rd_resp) && !mst_q;
    assign m1_rvalid  = (state == rd_resp) && mst_q;
    assign rready_sel = mst_q ? m1_rready : m0_rready;
    assign rdata      = rdata_q;
    assign rresp      = resp_okay;
    assign done       = (state == rd_resp) && rready_sel;

    always_comb begin
        for (int i = 0; i < num_slaves; i++) begin
            arvalid_vec[i]  = (state == rd_addr) && (sel_q == slave_idx_t'(i));
            rready_vec[i]   = (state == rd_data) && (sel_q == slave_idx_t'(i));
            s_rd[i].araddr  = addr_q;
            s_rd[i].arvalid = arvalid_vec[i];
            s_rd[i].rready  = rready_vec[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rd_idle;
        end else begin
            case (state)
                rd_idle: begin
                    if (take) begin
                        state <= rd_addr;
                    end
                end
                rd_addr: begin
                    if (ar_hs) begin
                        state <= rd_data;
                    end
                end
                rd_data: begin
                    if (r_hs) begin
                        state <= rd_resp;    // data valid to master next cycle
                    end
                end
                rd_resp: begin
                    if (rready_sel) begin
                        state <= rd_idle;
                    end
                end
                default: state <= rd_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            addr_q <= araddr_sel;
            sel_q  <= araddr_sel[addr_w-1 -: sel_w];
            mst_q  <= grant;
        end
        if (r_hs) begin
            rdata_q <= s_rsp[sel_q].rdata;
        end
    end

    a_rready_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(rready_vec)
    );

endmodule

// File: hw/write_path.sv
`timescale 1ns/1ps

module write_path import axil_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    grant_valid,
    input  logic                    grant,
    input  wr_req_t                 m0_wr_req,
    input  wr_req_t                 m1_wr_req,
    input  logic                    m0_bready,
    input  logic                    m1_bready,
    input  s_rsp_t [num_slaves-1:0] s_rsp,
    output logic                    m0_wr_ready,
    output logic                    m1_wr_ready,
    output logic                    m0_bvalid,
    output logic                    m1_bvalid,
    output resp_t                   bresp,
    output s_wr_t  [num_slaves-1:0] s_wr,
    output logic                    done
);

    wr_state_t             state;
    wr_req_t               req_q;        // request forwarded to the slave
    logic                  aw_done_q;    // slave has taken the address
    logic                  w_done_q;     // slave has taken the data
    slave_idx_t            sel;
    logic [num_slaves-1:0] awvalid_vec;
    logic [num_slaves-1:0] wvalid_vec;
    logic                  take;
    logic                  aw_hs;
    logic                  w_hs;
    logic                  bready_sel;

    assign sel  = req_q.addr[addr_w-1 -: sel_w];
    assign take = (state == wr_idle) && grant_valid;

    // one-cycle accept pulse to the granted master
    assign m0_wr_ready = take && !grant;
    assign m1_wr_ready = take && grant;

    assign aw_hs = awvalid_vec[sel] && s_rsp[sel].awready;
    assign w_hs  = wvalid_vec[sel] && s_rsp[sel].wready;

    // grant is held by the arbiter until done, so it steers the response
    assign m0_bvalid  = (state == wr_resp) && !grant;
    assign m1_bvalid  = (state == wr_resp) && grant;
    assign bready_sel = grant ? m1_bready : m0_bready;
    assign bresp      = resp_okay;
    assign done       = (state == wr_resp) && bready_sel;

    always_comb begin
        for (int i = 0; i < num_slaves; i++) begin
            awvalid_vec[i]  = (state == wr_send) && !aw_done_q && (sel == slave_idx_t'(i));
            wvalid_vec[i]   = (state == wr_send) && !w_done_q && (sel == slave_idx_t'(i));
            s_wr[i].awaddr  = req_q.addr;
            s_wr[i].awvalid = awvalid_vec[i];
            s_wr[i].wdata   = req_q.data;
            s_wr[i].wstrb   = req_q.strb;
            s_wr[i].wvalid  = wvalid_vec[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= wr_idle;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            case (state)
                wr_idle: begin
                    if (take) begin
                        state     <= wr_send;
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                    end
                end
                wr_send: begin
                    if (aw_hs) begin
                        aw_done_q <= 1'b1;
                    end
                    if (w_hs) begin
                        w_done_q <= 1'b1;
                    end
                    // address and data may land in either order
                    if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
                        state <= wr_resp;
                    end
                end
                wr_resp: begin
                    if (bready_sel) begin
                        state <= wr_idle;    // response accepted
                    end
                end
                default: state <= wr_idle;
            endcase
        end
    end

    // captured on the wr_ready cycle
    always_ff @(posedge clk) begin
        if (take) begin
            req_q <= grant ? m1_wr_req : m0_wr_req;
        end
    end

    a_aw_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(awvalid_vec)
    );

    a_b_single: assert property (
        @(posedge clk) disable iff (rst)
        !(m0_bvalid && m1_bvalid)
    );

endmodule

// File: list.f
hw/axil_pkg.sv
hw/master_arbiter.sv
hw/write_path.sv
hw/read_path.sv
hw/axil_2m16s_top.sv
verification/axil_slave_model.sv
verification/tb_axil_2m16s.sv

// File: verification/axil_slave_model.sv
`timescale 1ns/1ps

module axil_slave_model import axil_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  s_wr_t  [num_slaves-1:0] s_wr,
    input  s_rd_t  [num_slaves-1:0] s_rd,
    output s_rsp_t [num_slaves-1:0] s_rsp
);

    data_t      mem [num_slaves][16];   // word store, address bits 5:2
    slave_idx_t wr_log [64];            // slave of each completed write, in order
    logic [5:0] wr_count;
    logic [1:0] aw_cnt, w_cnt, ar_cnt;  // cycles left before ready
    logic [1:0] r_cnt;                  // cycles left before rvalid
    logic       aw_got, w_got, rvalid_q;
    slave_idx_t wr_sel, ar_sel, rd_sel;
    s_wr_t      wr_cur;
    data_t      rdata_q;
    logic       aw_hs, w_hs, ar_hs;

    always_comb begin
        wr_sel = '0;
        ar_sel = '0;
        for (int i = 0; i < num_slaves; i++) begin
            if (s_wr[i].awvalid || s_wr[i].wvalid) wr_sel = slave_idx_t'(i);
            if (s_rd[i].arvalid) ar_sel = slave_idx_t'(i);
            s_rsp[i].awready = s_wr[i].awvalid && (aw_cnt == 2'd0);
            s_rsp[i].wready  = s_wr[i].wvalid && (w_cnt == 2'd0);
            s_rsp[i].arready = s_rd[i].arvalid && (ar_cnt == 2'd0);
            s_rsp[i].rdata   = rdata_q;
            s_rsp[i].rvalid  = rvalid_q && (rd_sel == slave_idx_t'(i));
        end
        wr_cur = s_wr[wr_sel];
        aw_hs  = wr_cur.awvalid && (aw_cnt == 2'd0);
        w_hs   = wr_cur.wvalid && (w_cnt == 2'd0);
        ar_hs  = s_rd[ar_sel].arvalid && (ar_cnt == 2'd0);
    end

    always @(posedge clk) begin
        if (rst) begin
            aw_cnt   <= 2'($urandom % 4);
            w_cnt    <= 2'($urandom % 4);
            ar_cnt   <= 2'($urandom % 4);
            r_cnt    <= 2'd0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            rvalid_q <= 1'b0;
            rd_sel   <= '0;
            wr_count <= '0;
            for (int i = 0; i < num_slaves; i++) begin
                for (int j = 0; j < 16; j++) begin
                    mem[i][j] <= data_t'(32'h5a00_0000 | (i << 16) | (j << 4) | (i ^ j));
                end
            end
        end else begin
            if (aw_hs) aw_got <= 1'b1;
            if (w_hs) w_got <= 1'b1;
            if (wr_cur.awvalid) aw_cnt <= aw_hs ? 2'($urandom % 4) : aw_cnt - 2'd1;
            if (wr_cur.wvalid) w_cnt <= w_hs ? 2'($urandom % 4) : w_cnt - 2'd1;
            if ((aw_got || aw_hs) && (w_got || w_hs)) begin  // address and data both in
                for (int b = 0; b < 4; b++) begin
                    if (wr_cur.wstrb[b]) begin
                        mem[wr_sel][wr_cur.awaddr[5:2]][8*b +: 8] <= wr_cur.wdata[8*b +: 8];
                    end
                end
                wr_log[wr_count] <= wr_sel;
                wr_count         <= wr_count + 6'd1;
                aw_got           <= 1'b0;
                w_got            <= 1'b0;
            end
            if (s_rd[ar_sel].arvalid) ar_cnt <= ar_hs ? 2'($urandom % 4) : ar_cnt - 2'd1;
            if (ar_hs) begin
                rd_sel  <= ar_sel;
                rdata_q <= mem[ar_sel][s_rd[ar_sel].araddr[5:2]];
                r_cnt   <= 2'd1 + 2'($urandom % 3);  // rvalid 1 to 3 cycles later
            end
            if (r_cnt == 2'd1) rvalid_q <= 1'b1;
            if (r_cnt != 2'd0) r_cnt <= r_cnt - 2'd1;
            if (rvalid_q && s_rd[rd_sel].rready) rvalid_q <= 1'b0;
        end
    end

endmodule

// File: verification/tb_axil_2m16s.sv
`timescale 1ns/1ps

module tb_axil_2m16s import axil_pkg::*; ();

    localparam int clk_period = 40;
    localparam int num_tests  = 5;

    logic                    clk;
    logic                    rst;
    wr_req_t                 wr_req [2];    // index is the master id
    addr_t                   araddr [2];
    logic [1:0]              wr_valid, bready, arvalid, rready;
    logic [1:0]              wr_ready, bvalid, arready, rvalid;
    resp_t                   bresp [2];
    resp_t                   rresp [2];
    data_t                   rdata [2];
    s_wr_t  [num_slaves-1:0] s_wr;
    s_rd_t  [num_slaves-1:0] s_rd;
    s_rsp_t [num_slaves-1:0] s_rsp;

    axil_2m16s_top dut0 (.clk(clk), .rst(rst),
        .m0_wr_req(wr_req[0]), .m0_wr_valid(wr_valid[0]), .m0_wr_ready(wr_ready[0]),
        .m0_bvalid(bvalid[0]), .m0_bresp(bresp[0]), .m0_bready(bready[0]),
        .m0_araddr(araddr[0]), .m0_arvalid(arvalid[0]), .m0_arready(arready[0]),
        .m0_rdata(rdata[0]), .m0_rvalid(rvalid[0]), .m0_rresp(rresp[0]), .m0_rready(rready[0]),
        .m1_wr_req(wr_req[1]), .m1_wr_valid(wr_valid[1]), .m1_wr_ready(wr_ready[1]),
        .m1_bvalid(bvalid[1]), .m1_bresp(bresp[1]), .m1_bready(bready[1]),
        .m1_araddr(araddr[1]), .m1_arvalid(arvalid[1]), .m1_arready(arready[1]),
        .m1_rdata(rdata[1]), .m1_rvalid(rvalid[1]), .m1_rresp(rresp[1]), .m1_rready(rready[1]),
        .s_wr(s_wr), .s_rd(s_rd), .s_rsp(s_rsp));

    axil_slave_model model0 (.clk(clk), .rst(rst), .s_wr(s_wr), .s_rd(s_rd), .s_rsp(s_rsp));

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic fail_now(input string why);
        $display("error at %0t ns: %s", $time, why);
        stop_with_failure();
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_resp(input string name, input resp_t got, input resp_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_idx(input string name, input slave_idx_t got, input slave_idx_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // slave in the top four bits, word in bits 5:2
    function automatic addr_t word_addr(input int s, input int w);
        return {slave_idx_t'(s), 22'h0, 4'(w), 2'b00};
    endfunction

    function automatic data_t base_word(input int i);
        return data_t'(32'h1357_0000 + i * 32'h1111);
    endfunction

    function automatic data_t apply_strobe(input data_t old, input data_t wr, input strb_t s);
        data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) res[8*b +: 8] = wr[8*b +: 8];
        end
        return res;
    endfunction

    task automatic write_word(input bit m, input addr_t a, input data_t d, input strb_t s,
                              input int stall);
        @(posedge clk);
        wr_req[m]   <= '{addr: a, data: d, strb: s};
        wr_valid[m] <= 1'b1;
        do @(negedge clk); while (!wr_ready[m]);
        @(posedge clk);                         // request taken here
        wr_valid[m] <= 1'b0;
        do @(negedge clk); while (!bvalid[m]);
        repeat (stall) begin
            @(negedge clk);
            if (!bvalid[m]) fail_now("bvalid dropped before bready was given");
        end
        check_resp("bresp", bresp[m], resp_okay);
        @(posedge clk);
        bready[m] <= 1'b1;
        @(posedge clk);
        bready[m] <= 1'b0;
        @(negedge clk);
        if (bvalid[m]) fail_now("a second write response followed the accepted one");
    endtask

    task automatic read_word(input bit m, input addr_t a, input int stall, output data_t d);
        @(posedge clk);
        araddr[m]  <= a;
        arvalid[m] <= 1'b1;
        do @(negedge clk); while (!arready[m]);
        @(posedge clk);
        arvalid[m] <= 1'b0;
        do @(negedge clk); while (!rvalid[m]);
        repeat (stall) begin
            @(negedge clk);
            if (!rvalid[m]) fail_now("rvalid dropped before rready was given");
        end
        check_resp("rresp", rresp[m], resp_okay);
        d = rdata[m];
        @(posedge clk);
        rready[m] <= 1'b1;
        @(posedge clk);
        rready[m] <= 1'b0;
        @(negedge clk);
        if (rvalid[m]) fail_now("a second read response followed the accepted one");
    endtask

    task automatic reset_outputs_low();
        logic [num_slaves-1:0] s_side;
        @(negedge clk);
        for (int i = 0; i < num_slaves; i++) begin
            s_side[i] = s_wr[i].awvalid | s_wr[i].wvalid | s_rd[i].arvalid | s_rd[i].rready;
        end
        check_data("master valid/ready", data_t'({wr_ready, bvalid, arready, rvalid}), '0);
        check_data("slave valid/ready", data_t'(s_side), '0);
    endtask

    task automatic m0_write_every_slave();
        data_t d;
        for (int i = 0; i < num_slaves; i++) begin
            write_word(1'b0, word_addr(i, i), base_word(i), 4'hf, 0);
        end
        for (int i = 0; i < num_slaves; i++) begin
            read_word(1'b0, word_addr(i, i), 0, d);
            check_data($sformatf("m0 rdata slave %0d", i), d, base_word(i));
        end
    endtask

    task automatic m1_strobed_write();
        data_t d;
        write_word(1'b1, word_addr(10, 10), 32'hdead_beef, 4'b0101, 0);
        read_word(1'b1, word_addr(10, 10), 0, d);
        check_data("m1 strobed rdata", d, apply_strobe(base_word(10), 32'hdead_beef, 4'b0101));
    endtask

    task automatic same_cycle_writes();
        logic [5:0] base;
        data_t      d;
        base = model0.wr_count;
        fork                                    // both request on the same edge
            write_word(1'b0, word_addr(3, 9), 32'ha0a0_0003, 4'hf, 0);
            write_word(1'b1, word_addr(12, 9), 32'hb1b1_000c, 4'hf, 0);
        join
        check_idx("first logged write", model0.wr_log[base], 4'd3);
        check_idx("second logged write", model0.wr_log[base + 6'd1], 4'd12);
        read_word(1'b0, word_addr(3, 9), 0, d);
        check_data("slave 3 word 9", d, 32'ha0a0_0003);
        read_word(1'b0, word_addr(12, 9), 0, d);
        check_data("slave 12 word 9", d, 32'hb1b1_000c);
    endtask

    task automatic read_during_write();
        data_t d;
        for (int k = 0; k < 3; k++) begin
            fork
                read_word(1'b0, word_addr(k + 4, k + 4), 1 + int'($urandom % 6), d);
                write_word(1'b1, word_addr(k + 8, 2), data_t'(32'h7700_0000 | k), 4'hf,
                           1 + int'($urandom % 6));
            join
            check_data("m0 rdata during m1 write", d, base_word(k + 4));
            read_word(1'b0, word_addr(k + 8, 2), 0, d);
            check_data("m1 write readback", d, data_t'(32'h7700_0000 | k));
        end
    endtask

    initial begin
        #(num_tests * 200 * clk_period);        // 200 cycles per test
        fail_now("run timed out waiting for a response");
    end

    initial begin
        void'($urandom(32'h246e_64f6));
        clk      = 1'b0;
        rst      = 1'b1;
        wr_req   = '{default: '0};
        araddr   = '{default: '0};
        wr_valid = '0;
        bready   = '0;
        arvalid  = '0;
        rready   = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        reset_outputs_low();
        m0_write_every_slave();
        m1_strobed_write();
        same_cycle_writes();
        read_during_write();
        $display("sim passed");
        $finish;
    end

endmodule
